// ==== host_bridge.f ====
hdl/host_bridge_pkg.sv
hdl/mem_port_if.sv
hdl/cmd_frame_if.sv
hdl/host_serial_rx.sv
hdl/host_serial_tx.sv
hdl/cmd_executor.sv
hdl/word_ram.sv
hdl/host_bridge.sv
tests/tb_host_bridge.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_host_bridge \
  -f host_bridge.f -Mdir obj_dir -o tb_host_bridge \
  && ./obj_dir/tb_host_bridge | tee /dev/stderr | grep -q "Regression passed" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== tests/tb_host_bridge.sv ====
`timescale 1ns/1ps

module tb_host_bridge import host_bridge_pkg::*; ();

  localparam int BURST       = 8;
  localparam int MEM_W       = 8;
  localparam int BUSY_LIMIT  = 4000;  // sys_clk cycles
  localparam int REPLY_LIMIT = 64;    // host_sclk periods

  logic       sys_clk;
  logic       sys_rst_n;
  logic       host_sclk;
  logic       host_sdi;
  word_t      fifo_din;
  logic       host_sdo;
  logic       busy;
  logic       sloe_n;
  logic       slrd_n;
  logic       slwr_n;
  logic [1:0] fifo_adr;
  word_t      fifo_dout;
  logic       fifo_dout_en;

  int    value_errors;
  int    other_errors;
  word_t fifo_q[$];       // words offered to the bridge
  word_t dout_q[$];       // words written out by the bridge
  word_t burst_words[$];
  byte_t base_addr;

  host_bridge #(.BURST_WORDS(BURST), .MEM_ADDR_W(MEM_W)) UUT (.*);

  always #50 sys_clk = ~sys_clk;

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      value_errors++;
      $display("ERROR %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("ERROR %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_adr(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      value_errors++;
      $display("ERROR %s: expected %h, got %h", name, exp, act);
    end
  endtask

  // fifo model advances after each read strobe
  always @(posedge slrd_n) begin
    #1;
    if (fifo_q.size() > 0) begin
      void'(fifo_q.pop_front());
    end
    fifo_din = (fifo_q.size() > 0) ? fifo_q[0] : '0;
  end

  always @(negedge slwr_n) begin
    #1;
    check_bit("fifo_dout_en", 1'b1, fifo_dout_en);
    dout_q.push_back(fifo_dout);
  end

  always @(negedge sys_clk) begin
    if (sys_rst_n === 1'b1 && fifo_dout_en === 1'b1) begin
      check_adr("fifo_adr", 2'd2, fifo_adr);
    end
  end

  // one host clock period with host_sdo sampled just before the rise
  task automatic sclk_period(output logic sdo_seen);
    repeat (10) @(posedge sys_clk);
    #1;
    sdo_seen  = host_sdo;
    host_sclk = 1'b1;
    repeat (10) @(posedge sys_clk);
    #1;
    host_sclk = 1'b0;
  endtask

  task automatic wait_not_busy();
    int n;
    n = 0;
    while (busy !== 1'b0 && n < BUSY_LIMIT) begin
      @(posedge sys_clk);
      #1;
      n++;
    end
    if (busy !== 1'b0) begin
      other_errors++;
      $display("TIMEOUT busy still high after %0d cycles", BUSY_LIMIT);
    end
  endtask

  task automatic send_frame(input byte_t cmd, input byte_t dat);
    logic [FRAME_BITS:0] bits;
    logic                unused;
    bits = {dat, cmd, 1'b1};  // start bit first then lsb first
    wait_not_busy();
    for (int i = 0; i <= FRAME_BITS; i++) begin
      host_sdi = bits[i];
      sclk_period(unused);
    end
    host_sdi = 1'b0;
  endtask

  task automatic get_reply(output word_t word);
    logic b;
    logic started;
    int   got;
    int   n;
    started = 1'b0;
    got     = 0;
    n       = 0;
    word    = '0;
    while (got <= FRAME_BITS && n < REPLY_LIMIT) begin
      sclk_period(b);
      n++;
      if (!started) begin
        started = (b === 1'b1);
      end else if (got < FRAME_BITS) begin
        word[got] = b;
        got++;
      end else begin
        check_bit("host_sdo stop bit", 1'b0, b);  // this rise also acks
        got++;
      end
    end
    if (got <= FRAME_BITS) begin
      other_errors++;
      $display("TIMEOUT no complete reply within %0d host_sclk periods", REPLY_LIMIT);
    end
  endtask

  task automatic write_word(input byte_t a0, input word_t data);
    send_frame(OP_SET_ADDR0, a0);
    send_frame(OP_SET_DATA0, data[7:0]);
    send_frame(OP_SET_DATA1, data[15:8]);
    send_frame(OP_WRITE, 8'h00);
    wait_not_busy();
  endtask

  task automatic read_word(input byte_t a0, output word_t data);
    send_frame(OP_SET_ADDR0, a0);
    send_frame(OP_READ, 8'h00);
    get_reply(data);
    wait_not_busy();
  endtask

  task automatic reset_state();
    check_bit("busy", 1'b0, busy);
    check_bit("host_sdo", 1'b0, host_sdo);
    check_bit("fifo_dout_en", 1'b0, fifo_dout_en);
    check_bit("sloe_n", 1'b1, sloe_n);
    check_bit("slrd_n", 1'b1, slrd_n);
    check_bit("slwr_n", 1'b1, slwr_n);
    check_adr("fifo_adr", 2'd0, fifo_adr);
  endtask

  task automatic single_write_read();
    byte_t a0;
    word_t wa;
    word_t wb;
    word_t rd;
    a0 = byte_t'($urandom);
    wa = word_t'($urandom);
    wb = word_t'($urandom);
    send_frame(OP_SET_ADDR1, byte_t'($urandom));
    send_frame(OP_SET_ADDR2, byte_t'($urandom));
    write_word(a0 ^ 8'h01, wb);  // neighbour must survive
    write_word(a0, wa);
    read_word(a0, rd);
    check_word("single read reply", wa, rd);
    read_word(a0 ^ 8'h01, rd);
    check_word("neighbour read reply", wb, rd);
  endtask

  task automatic burst_write();
    word_t rd;
    base_addr = byte_t'($urandom);
    burst_words.delete();
    for (int i = 0; i < BURST; i++) begin
      burst_words.push_back(word_t'($urandom));
    end
    fifo_q   = burst_words;
    fifo_din = fifo_q[0];
    send_frame(OP_SET_ADDR0, base_addr);
    send_frame(OP_BURST_WRITE, 8'h00);
    get_reply(rd);
    check_word("burst write reply", 16'h3412, rd);
    wait_not_busy();
    for (int i = 0; i < BURST; i++) begin
      read_word(base_addr + byte_t'(i), rd);
      check_word($sformatf("burst word %0d reply", i), burst_words[i], rd);
    end
  endtask

  task automatic burst_read();
    word_t rd;
    word_t sum;
    sum = '0;
    dout_q.delete();
    send_frame(OP_SET_ADDR0, base_addr);
    send_frame(OP_BURST_READ, 8'h00);
    get_reply(rd);
    wait_not_busy();
    if (dout_q.size() != BURST) begin
      other_errors++;
      $display("burst read wrote %0d words to the FIFO, expected %0d", dout_q.size(), BURST);
    end
    for (int i = 0; i < BURST && i < dout_q.size(); i++) begin
      check_word($sformatf("fifo_dout word %0d", i), burst_words[i], dout_q[i]);
    end
    for (int i = 0; i < BURST; i++) begin
      sum = sum + burst_words[i];  // wraps at 16 bits
    end
    check_word("burst read sum reply", sum, rd);
  endtask

  task automatic unknown_opcode();
    logic  b;
    logic  seen;
    word_t rd;
    seen = 1'b0;
    send_frame(8'h55, 8'h00);
    wait_not_busy();
    for (int i = 0; i < 40; i++) begin
      sclk_period(b);
      seen = seen | b;
    end
    check_bit("host_sdo start bit", 1'b0, seen);
    read_word(base_addr, rd);
    check_word("read after unknown opcode", burst_words[0], rd);
  endtask

  initial begin
    value_errors = 0;
    other_errors = 0;
    sys_clk      = 1'b0;
    sys_rst_n    = 1'b0;
    host_sclk    = 1'b0;
    host_sdi     = 1'b0;
    fifo_din     = '0;
    void'($urandom(32'h196c));
    repeat (16) @(posedge sys_clk);
    #1;
    sys_rst_n = 1'b1;
    @(posedge sys_clk);
    #1;
    reset_state();
    single_write_read();
    burst_write();
    burst_read();
    unknown_opcode();
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== hdl/host_bridge.sv ====
`timescale 1ns/1ps

module host_bridge import host_bridge_pkg::*; #(
  parameter int BURST_WORDS = 512,
  parameter int MEM_ADDR_W  = 12
) (
  input  logic       sys_clk,
  input  logic       sys_rst_n,
  input  logic       host_sclk,
  input  logic       host_sdi,
  input  word_t      fifo_din,
  output logic       host_sdo,
  output logic       busy,
  output logic       sloe_n,
  output logic       slrd_n,
  output logic       slwr_n,
  output logic [1:0] fifo_adr,
  output word_t      fifo_dout,
  output logic       fifo_dout_en
);

  logic  sclk_rise;   // shared host clock edge
  word_t reply_word;
  logic  reply_req;
  logic  reply_ack;

  cmd_frame_if frame_bus ();
  mem_port_if  mem_bus ();

  host_serial_rx u_rx (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .host_sclk (host_sclk),
    .host_sdi  (host_sdi),
    .sclk_rise (sclk_rise),
    .frame     (frame_bus.sender)
  );

  host_serial_tx u_tx (
    .sys_clk    (sys_clk),
    .sys_rst_n  (sys_rst_n),
    .sclk_rise  (sclk_rise),
    .reply_word (reply_word),
    .reply_req  (reply_req),
    .reply_ack  (reply_ack),
    .host_sdo   (host_sdo)
  );

  cmd_executor #(.BURST_WORDS(BURST_WORDS)) u_exec (
    .sys_clk      (sys_clk),
    .sys_rst_n    (sys_rst_n),
    .fifo_din     (fifo_din),
    .reply_ack    (reply_ack),
    .busy         (busy),
    .sloe_n       (sloe_n),
    .slrd_n       (slrd_n),
    .slwr_n       (slwr_n),
    .fifo_adr     (fifo_adr),
    .fifo_dout    (fifo_dout),
    .fifo_dout_en (fifo_dout_en),
    .reply_word   (reply_word),
    .reply_req    (reply_req),
    .frame        (frame_bus.receiver),
    .mem          (mem_bus.requester)
  );

  word_ram #(.MEM_ADDR_W(MEM_ADDR_W)) u_ram (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .mem       (mem_bus.memory)
  );

endmodule

// ==== hdl/word_ram.sv ====
`timescale 1ns/1ps

module word_ram import host_bridge_pkg::*; #(
  parameter int MEM_ADDR_W = 12
) (
  input  logic sys_clk,
  input  logic sys_rst_n,
  mem_port_if.memory mem
);

  word_t ram [2**MEM_ADDR_W];

  logic [MEM_ADDR_W-1:0] idx;
  logic                  ack_busy;
  logic                  rd_fire;
  logic                  wr_fire;

  assign idx      = mem.addr[MEM_ADDR_W-1:0];  // low address bits only
  assign ack_busy = mem.rd_ack | mem.wr_ack;   // one request per two cycles
  assign rd_fire  = mem.rd_req && !ack_busy;
  assign wr_fire  = mem.wr_req && !mem.rd_req && !ack_busy;  // read wins

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      mem.rd_ack <= 1'b0;
      mem.wr_ack <= 1'b0;
    end else begin
      mem.rd_ack <= rd_fire;
      mem.wr_ack <= wr_fire;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (wr_fire) begin
      ram[idx] <= mem.wdata;
    end
    if (rd_fire) begin
      mem.rdata <= ram[idx];  // valid with rd_ack
    end
  end

  a_single_request: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n) !(mem.rd_req && mem.wr_req)
  );

endmodule

// ==== hdl/cmd_executor.sv ====
`timescale 1ns/1ps

module cmd_executor import host_bridge_pkg::*; #(
  parameter int BURST_WORDS = 512
) (
  input  logic       sys_clk,
  input  logic       sys_rst_n,
  input  word_t      fifo_din,
  input  logic       reply_ack,
  output logic       busy,
  output logic       sloe_n,
  output logic       slrd_n,
  output logic       slwr_n,
  output logic [1:0] fifo_adr,
  output word_t      fifo_dout,
  output logic       fifo_dout_en,
  output word_t      reply_word,
  output logic       reply_req,
  cmd_frame_if.receiver frame,
  mem_port_if.requester mem
);

  localparam int CNT_W = $clog2(BURST_WORDS + 1);

  typedef enum logic [2:0] {
    S_IDLE, S_DECODE, S_MEM_WAIT, S_BW, S_BR_READ, S_BR_STROBE, S_REPLY
  } state_t;

  state_t           state;
  opcode_t          op_q;
  byte_t            data0;
  byte_t            data1;
  byte_t            address0;
  byte_t            address1;
  byte_t            address2;
  logic [3:0]       phase;     // burst write phase or strobe count
  logic [CNT_W-1:0] word_cnt;
  word_t            sum;       // wraps at 16 bits
  logic             last_word;

  assign busy      = (state != S_IDLE);
  assign last_word = (word_cnt == CNT_W'(BURST_WORDS - 1));

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state        <= S_IDLE;
      op_q         <= OP_NOP;
      frame.taken  <= 1'b0;
      data0        <= '0;
      data1        <= '0;
      address0     <= '0;
      address1     <= '0;
      address2     <= '0;
      phase        <= '0;
      word_cnt     <= '0;
      sum          <= '0;
      sloe_n       <= 1'b1;
      slrd_n       <= 1'b1;
      slwr_n       <= 1'b1;
      fifo_adr     <= FIFO_ADR_IN;
      fifo_dout    <= '0;
      fifo_dout_en <= 1'b0;
      reply_word   <= '0;
      reply_req    <= 1'b0;
      mem.addr     <= '0;
      mem.wdata    <= '0;
      mem.rd_req   <= 1'b0;
      mem.wr_req   <= 1'b0;
    end else begin
      frame.taken <= 1'b0;
      case (state)
        S_IDLE: begin
          if (frame.valid) begin
            frame.taken <= 1'b1;
            op_q        <= opcode_t'(frame.cmd);
            state       <= S_DECODE;
          end
        end
        S_DECODE: begin  // frame.dat still held this cycle
          state <= S_IDLE;
          case (op_q)
            OP_SET_DATA0: data0    <= frame.dat;
            OP_SET_DATA1: data1    <= frame.dat;
            OP_SET_ADDR0: address0 <= frame.dat;
            OP_SET_ADDR1: address1 <= frame.dat;
            OP_SET_ADDR2: address2 <= frame.dat;
            OP_WRITE: begin
              mem.addr   <= {address2, address1, address0};
              mem.wdata  <= {data1, data0};
              mem.wr_req <= 1'b1;
              state      <= S_MEM_WAIT;
            end
            OP_READ: begin
              mem.addr   <= {address2, address1, address0};
              mem.rd_req <= 1'b1;
              state      <= S_MEM_WAIT;
            end
            OP_BURST_WRITE: begin
              mem.addr <= {address2, address1, address0};
              sloe_n   <= 1'b0;
              slrd_n   <= 1'b0;  // phase 0 of first word
              phase    <= '0;
              word_cnt <= '0;
              state    <= S_BW;
            end
            OP_BURST_READ: begin
              mem.addr     <= {address2, address1, address0};
              mem.rd_req   <= 1'b1;
              sum          <= '0;
              word_cnt     <= '0;
              fifo_adr     <= FIFO_ADR_OUT;
              fifo_dout_en <= 1'b1;
              state        <= S_BR_READ;
            end
            default: ;  // nop and unknown codes just finish
          endcase
        end
        S_MEM_WAIT: begin
          if (mem.wr_ack) begin
            mem.wr_req <= 1'b0;
            state      <= S_IDLE;
          end else if (mem.rd_ack) begin
            mem.rd_req <= 1'b0;
            reply_word <= mem.rdata;
            reply_req  <= 1'b1;
            state      <= S_REPLY;
          end
        end
        S_BW: begin
          case (phase)
            4'd0: phase <= 4'd1;
            4'd1: begin
              slrd_n     <= 1'b1;      // fifo advances on this rise
              mem.wdata  <= fifo_din;
              mem.wr_req <= 1'b1;
              phase      <= 4'd2;
            end
            4'd2: begin
              if (mem.wr_ack) begin
                mem.wr_req <= 1'b0;
                phase      <= 4'd3;
              end
            end
            default: begin
              mem.addr <= mem.addr + 1'b1;
              word_cnt <= word_cnt + 1'b1;
              phase    <= '0;
              if (last_word) begin
                sloe_n     <= 1'b1;
                reply_word <= REPLY_BURST_DONE;
                reply_req  <= 1'b1;
                state      <= S_REPLY;
              end else begin
                slrd_n <= 1'b0;
              end
            end
          endcase
        end
        S_BR_READ: begin
          if (mem.rd_ack) begin
            mem.rd_req <= 1'b0;
            fifo_dout  <= mem.rdata;
            sum        <= sum + mem.rdata;
            slwr_n     <= 1'b0;
            phase      <= '0;
            state      <= S_BR_STROBE;
          end
        end
        S_BR_STROBE: begin
          phase <= phase + 1'b1;
          if (phase == 4'(STROBE_CYCLES - 1)) begin
            slwr_n   <= 1'b1;
            mem.addr <= mem.addr + 1'b1;
            word_cnt <= word_cnt + 1'b1;
            if (last_word) begin
              fifo_adr     <= FIFO_ADR_IN;
              fifo_dout_en <= 1'b0;
              reply_word   <= sum;
              reply_req    <= 1'b1;
              state        <= S_REPLY;
            end else begin
              mem.rd_req <= 1'b1;   // next word
              state      <= S_BR_READ;
            end
          end
        end
        S_REPLY: begin
          if (reply_ack) begin
            reply_req <= 1'b0;
            state     <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  a_strobes_exclusive: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n) !(!slrd_n && !slwr_n)
  );

  a_dout_channel: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n) fifo_dout_en |-> fifo_adr == FIFO_ADR_OUT
  );

endmodule

// ==== hdl/host_serial_tx.sv ====
`timescale 1ns/1ps

module host_serial_tx import host_bridge_pkg::*; (
  input  logic  sys_clk,
  input  logic  sys_rst_n,
  input  logic  sclk_rise,
  input  word_t reply_word,
  input  logic  reply_req,
  output logic  reply_ack,
  output logic  host_sdo
);

  localparam int CNT_W = $clog2(FRAME_BITS + 3);

  logic [CNT_W-1:0]      bit_cnt;    // 0 idle, then start, data, stop, ack
  logic [FRAME_BITS-1:0] shift_reg;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      bit_cnt   <= '0;
      shift_reg <= '0;
      host_sdo  <= 1'b0;
      reply_ack <= 1'b0;
    end else begin
      reply_ack <= 1'b0;
      if (sclk_rise) begin
        if (bit_cnt == '0) begin
          if (reply_req) begin
            host_sdo  <= 1'b1;        // start bit
            shift_reg <= reply_word;
            bit_cnt   <= CNT_W'(1);
          end
        end else if (bit_cnt <= CNT_W'(FRAME_BITS)) begin
          host_sdo  <= shift_reg[0];  // low byte first
          shift_reg <= shift_reg >> 1;
          bit_cnt   <= bit_cnt + 1'b1;
        end else if (bit_cnt == CNT_W'(FRAME_BITS + 1)) begin
          host_sdo <= 1'b0;           // stop bit
          bit_cnt  <= bit_cnt + 1'b1;
        end else begin
          // stop bit has been sampled by the host
          reply_ack <= 1'b1;
          bit_cnt   <= '0;
        end
      end
    end
  end

  a_reply_word_stable: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n)
    reply_req && !reply_ack |=> $stable(reply_word)
  );

endmodule

// ==== hdl/host_serial_rx.sv ====
`timescale 1ns/1ps

module host_serial_rx import host_bridge_pkg::*; (
  input  logic sys_clk,
  input  logic sys_rst_n,
  input  logic host_sclk,
  input  logic host_sdi,
  output logic sclk_rise,
  cmd_frame_if.sender frame
);

  localparam int CNT_W = $clog2(FRAME_BITS + 1);

  logic sclk_meta;
  logic sclk_sync;
  logic sclk_prev;
  logic sdi_meta;
  logic sdi_sync;

  logic [CNT_W-1:0]      bit_cnt;    // 0 waits for start bit
  logic [FRAME_BITS-1:0] shift_reg;
  logic                  valid_q;

  // two flop synchronizers, sdi kept aligned with sclk
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      sclk_meta <= 1'b0;
      sclk_sync <= 1'b0;
      sclk_prev <= 1'b0;
      sdi_meta  <= 1'b0;
      sdi_sync  <= 1'b0;
    end else begin
      sclk_meta <= host_sclk;
      sclk_sync <= sclk_meta;
      sclk_prev <= sclk_sync;
      sdi_meta  <= host_sdi;
      sdi_sync  <= sdi_meta;
    end
  end

  assign sclk_rise = sclk_sync & ~sclk_prev;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      bit_cnt   <= '0;
      shift_reg <= '0;
      valid_q   <= 1'b0;
    end else begin
      if (frame.taken) begin
        valid_q <= 1'b0;
      end
      if (sclk_rise) begin
        if (bit_cnt == '0) begin
          if (sdi_sync && !valid_q) begin  // start bit, ignored while a frame waits
            bit_cnt <= CNT_W'(1);
          end
        end else begin
          shift_reg <= {sdi_sync, shift_reg[FRAME_BITS-1:1]};  // lsb first
          if (bit_cnt == CNT_W'(FRAME_BITS)) begin
            bit_cnt <= '0;
            valid_q <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
      end
    end
  end

  assign frame.cmd   = shift_reg[7:0];
  assign frame.dat   = shift_reg[15:8];
  assign frame.valid = valid_q;

  // a pending frame blocks reception
  a_no_shift_while_valid: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n)
    frame.valid |=> $stable(bit_cnt)
  );

endmodule

// ==== hdl/cmd_frame_if.sv ====
`timescale 1ns/1ps

interface cmd_frame_if import host_bridge_pkg::*; ();

  byte_t cmd;
  byte_t dat;
  logic  valid;  // held until taken
  logic  taken;  // single cycle pulse

  modport sender (
    output cmd,
    output dat,
    output valid,
    input  taken
  );

  modport receiver (
    input  cmd,
    input  dat,
    input  valid,
    output taken
  );

endinterface

// ==== hdl/mem_port_if.sv ====
`timescale 1ns/1ps

interface mem_port_if import host_bridge_pkg::*; ();

  addr_t addr;    // full byte address, ram uses the low bits
  word_t wdata;
  word_t rdata;   // valid in the rd_ack cycle
  logic  rd_req;
  logic  rd_ack;
  logic  wr_req;
  logic  wr_ack;

  // requests hold until acked
  modport requester (
    output addr,
    output wdata,
    output rd_req,
    output wr_req,
    input  rdata,
    input  rd_ack,
    input  wr_ack
  );

  modport memory (
    input  addr,
    input  wdata,
    input  rd_req,
    input  wr_req,
    output rdata,
    output rd_ack,
    output wr_ack
  );

endinterface

// ==== hdl/host_bridge_pkg.sv ====
package host_bridge_pkg;

  // basic payload types
  typedef logic [7:0]  byte_t;   // command or data byte
  typedef logic [15:0] word_t;   // memory, reply and fifo word
  typedef logic [23:0] addr_t;   // three address bytes

  // host command set
  typedef enum logic [7:0] {
    OP_NOP         = 8'h00,
    OP_SET_DATA0   = 8'h10,  // data low byte
    OP_SET_DATA1   = 8'h11,  // data high byte
    OP_SET_ADDR0   = 8'h12,
    OP_SET_ADDR1   = 8'h13,
    OP_SET_ADDR2   = 8'h14,
    OP_WRITE       = 8'hA0,  // single word write
    OP_READ        = 8'hA1,  // single word read, replies word
    OP_BURST_WRITE = 8'hA2,  // fifo into memory
    OP_BURST_READ  = 8'hA3   // memory out to fifo
  } opcode_t;

  // payload bits of a command or reply frame
  localparam int FRAME_BITS = 16;

  // reply sent once a burst write completes
  localparam word_t REPLY_BURST_DONE = 16'h3412;

  // fifo channel select
  localparam logic [1:0] FIFO_ADR_IN  = 2'd0;  // idle and burst write
  localparam logic [1:0] FIFO_ADR_OUT = 2'd2;  // burst read

  // write strobe length per burst read word
  localparam int STROBE_CYCLES = 4;

endpackage
